//--- files.f
+incdir+source
source/idiv_pkg.sv
source/idiv_controller.sv
source/idiv_datapath.sv
source/idiv_top.sv
verif/idiv_props.sv
verif/idiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the divider testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f files.f --top-module idiv_tb \
    --Mdir obj_dir -o idiv_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/idiv_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

//--- verif/idiv_tb.sv
/*
 * Testbench for the iterative divider. Inputs change on the falling edge,
 * results are checked on the rising edge where v_o and yumi_i are both high.
 * Expects the default 32-bit width for the literal operands below.
 */
`include "idiv_cfg.svh"

module idiv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W          = `IDIV_WIDTH;
    localparam int NUM_OPS    = 230;
    localparam int MAX_YUMI   = 10;
    localparam int OP_CYCLES  = W + 8 + MAX_YUMI + 4;
    localparam int TIMEOUT_NS = (NUM_OPS * OP_CYCLES + 100) * 10;

    localparam logic [W-1:0] MIN_NEG  = {1'b1, {(W-1){1'b0}}};
    localparam logic [W-1:0] ALL_ONES = {W{1'b1}};

    logic         clk_i;
    logic         reset_i;
    logic         v_i;
    logic         ready_o;
    logic [W-1:0] dividend_i;
    logic [W-1:0] divisor_i;
    logic         signed_div_i;
    logic         v_o;
    logic         yumi_i;
    logic [W-1:0] quotient_o;
    logic [W-1:0] remainder_o;

    // expected {quotient, remainder} in issue order
    logic [2*W-1:0] expected[$];

    string cur_test;
    int    seed = 89;
    int    chk_errors = 0;
    int    cmp_errors = 0;
    int    err_base;
    int    ops = 0;
    int    test_ops;
    int    tests = 0;

    idiv_top u_idiv_top (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .v_i          (v_i),
        .ready_o      (ready_o),
        .dividend_i   (dividend_i),
        .divisor_i    (divisor_i),
        .signed_div_i (signed_div_i),
        .v_o          (v_o),
        .yumi_i       (yumi_i),
        .quotient_o   (quotient_o),
        .remainder_o  (remainder_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ==============================
    // reference model
    // ==============================

    function automatic logic [2*W-1:0] reference_div(input logic [W-1:0] a,
                                                     input logic [W-1:0] b,
                                                     input logic         sgn);
        logic [W-1:0] q;
        logic [W-1:0] r;
        logic [W-1:0] mag_a;
        logic [W-1:0] mag_b;
        logic         neg_a;
        logic         neg_b;
        neg_a = sgn & a[W-1];
        neg_b = sgn & b[W-1];
        mag_a = neg_a ? -a : a;
        mag_b = neg_b ? -b : b;
        if (b == '0) begin
            q = ALL_ONES;
            r = a;
        end else if (sgn && a == MIN_NEG && b == ALL_ONES) begin
            q = a;
            r = '0;
        end else begin
            // truncate toward zero, remainder follows the dividend
            q = mag_a / mag_b;
            r = mag_a % mag_b;
            if (neg_a ^ neg_b) begin
                q = -q;
            end
            if (neg_a) begin
                r = -r;
            end
        end
        return {q, r};
    endfunction

    // ==============================
    // stimulus helpers
    // ==============================

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = chk_errors + cmp_errors;
        test_ops = 0;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s: %0d operations, %0d errors", cur_test, test_ops,
                 chk_errors + cmp_errors - err_base);
    endtask

    // one division; hold keeps v_i high with other operands while busy
    task automatic divide_once(input logic [W-1:0] a, input logic [W-1:0] b,
                               input logic sgn, input int dly, input bit hold);
        logic [W-1:0] held_q;
        logic [W-1:0] held_r;
        int           k;
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        dividend_i   = a;
        divisor_i    = b;
        signed_div_i = sgn;
        v_i          = 1'b1;
        expected.push_back(reference_div(a, b, sgn));
        @(negedge clk_i);
        if (hold) begin
            dividend_i = ~a;
            divisor_i  = ~b;
        end else begin
            v_i = 1'b0;
        end
        while (!v_o) @(negedge clk_i);
        held_q = quotient_o;
        held_r = remainder_o;
        for (k = 0; k < dly; k++) begin
            @(negedge clk_i);
            if (!v_o || ready_o) begin
                chk_errors++;
                $display("Fail %s: expected v_o=1 ready_o=0, actual v_o=%0b ready_o=%0b",
                         cur_test, v_o, ready_o);
            end
            if (quotient_o !== held_q || remainder_o !== held_r) begin
                chk_errors++;
                $display("Fail %s: expected held q=%h r=%h, actual q=%h r=%h",
                         cur_test, held_q, held_r, quotient_o, remainder_o);
            end
        end
        v_i    = 1'b0;
        yumi_i = 1'b1;
        @(negedge clk_i);
        yumi_i = 1'b0;
        // ready returns one cycle after yumi
        if (!ready_o || v_o) begin
            chk_errors++;
            $display("Fail %s: expected ready_o=1 v_o=0, actual ready_o=%0b v_o=%0b",
                     cur_test, ready_o, v_o);
        end
        ops++;
        test_ops++;
    endtask

    // ==============================
    // result comparison
    // ==============================

    initial begin
        logic [2*W-1:0] exp_val;
        forever begin
            @(posedge clk_i);
            if (!reset_i && v_o && yumi_i) begin
                if (expected.size() == 0) begin
                    cmp_errors++;
                    $display("%s: result consumed with no operation pending", cur_test);
                end else begin
                    exp_val = expected.pop_front();
                    if (quotient_o !== exp_val[2*W-1:W] || remainder_o !== exp_val[W-1:0]) begin
                        cmp_errors++;
                        $display("Fail %s: expected q=%h r=%h, actual q=%h r=%h", cur_test,
                                 exp_val[2*W-1:W], exp_val[W-1:0], quotient_o, remainder_o);
                    end
                end
            end
        end
    end

    // watchdog sized for the longest possible operation
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: divider did not finish all operations in time");
        $display("STATUS: FAIL");
        $finish;
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin
        logic [31:0]  rnd;
        logic [W-1:0] ra;
        logic [W-1:0] rb;
        int           i;
        reset_i      = 1'b1;
        v_i          = 1'b0;
        yumi_i       = 1'b0;
        dividend_i   = '0;
        divisor_i    = '0;
        signed_div_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        begin_test("reset");
        if (!ready_o || v_o) begin
            chk_errors++;
            $display("Fail reset: expected ready_o=1 v_o=0, actual ready_o=%0b v_o=%0b",
                     ready_o, v_o);
        end
        end_test();

        begin_test("unsigned_directed");
        divide_once(100, 7, 1'b0, 0, 1'b0);
        divide_once(5, 5, 1'b0, 1, 1'b0);
        divide_once(ALL_ONES, ALL_ONES, 1'b0, 0, 1'b0);
        divide_once(ALL_ONES, 1, 1'b0, 2, 1'b0);
        divide_once(ALL_ONES, 2, 1'b0, 0, 1'b0);
        divide_once(3, 10, 1'b0, 0, 1'b0);
        divide_once(0, 5, 1'b0, 0, 1'b0);
        end_test();

        begin_test("signed_combos");
        divide_once(7, 2, 1'b1, 0, 1'b0);
        divide_once(-7, 2, 1'b1, 0, 1'b0);
        divide_once(7, -2, 1'b1, 1, 1'b0);
        divide_once(-7, -2, 1'b1, 0, 1'b0);
        divide_once(1000, -33, 1'b1, 0, 1'b0);
        divide_once(-1000, 33, 1'b1, 3, 1'b0);
        divide_once(MIN_NEG, 2, 1'b1, 0, 1'b0);
        divide_once(-6, -3, 1'b1, 0, 1'b0);
        end_test();

        begin_test("zero_divisor");
        divide_once(12345, 0, 1'b0, 0, 1'b0);
        divide_once(ALL_ONES, 0, 1'b0, 0, 1'b0);
        divide_once(12345, 0, 1'b1, 0, 1'b0);
        divide_once(-12345, 0, 1'b1, 2, 1'b0);
        end_test();

        begin_test("signed_overflow");
        divide_once(MIN_NEG, ALL_ONES, 1'b1, 0, 1'b0);
        end_test();

        begin_test("backpressure");
        divide_once(1000, 7, 1'b0, MAX_YUMI, 1'b1);
        divide_once(-1000, 7, 1'b1, 6, 1'b1);
        end_test();

        begin_test("random_stress");
        for (i = 0; i < 200; i++) begin
            ra  = $random(seed);
            rb  = $random(seed);
            rnd = $random(seed);
            // mix in short divisors, zero divisors and the overflow pair
            rb = rb >> rnd[9:5];
            if (rnd[14:10] == 5'd0) begin
                rb = '0;
            end
            if (rnd[19:15] == 5'd0) begin
                ra = MIN_NEG;
                rb = ALL_ONES;
            end
            divide_once(ra, rb, rnd[0], int'(rnd[4:2]), 1'b0);
        end
        end_test();

        if (expected.size() != 0) begin
            chk_errors++;
            $display("%0d results were never returned by the divider", expected.size());
        end

        $display("summary: %0d tests, %0d operations, %0d errors", tests, ops,
                 chk_errors + cmp_errors);
        if (chk_errors + cmp_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/idiv_props.sv
/*
 * Handshake properties of the divider, bound to every idiv_top instance.
 * Only the top level ports are observed.
 */
`include "idiv_cfg.svh"

module idiv_props (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   ready_o,
    input logic                   v_o,
    input logic                   yumi_i,
    input logic [`IDIV_WIDTH-1:0] quotient_o,
    input logic [`IDIV_WIDTH-1:0] remainder_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // input and output sides never open together
    ready_excludes_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ready_o && v_o))
        else $error("ready_o and v_o are high together");

    // result holds until it is consumed
    result_held: assert property (@(posedge clk_i) disable iff (reset_i)
        (v_o && !yumi_i) |=> (v_o && $stable(quotient_o) && $stable(remainder_o)))
        else $error("v_o or a result changed before yumi_i");

    yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        yumi_i |-> v_o)
        else $error("yumi_i raised while v_o is low");

    // idle right after reset
    idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> (!v_o && ready_o))
        else $error("divider not idle after reset");

endmodule

bind idiv_top idiv_props u_idiv_props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ready_o     (ready_o),
    .v_o         (v_o),
    .yumi_i      (yumi_i),
    .quotient_o  (quotient_o),
    .remainder_o (remainder_o)
);

//--- source/idiv_top.sv
/*
 * Iterative integer divider, valid/ready in and valid/yumi out.
 * Inputs are only sampled while ready_o is high, results hold until yumi_i.
 */
`include "idiv_cfg.svh"

module idiv_top (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    v_i,
    output logic                    ready_o,
    input  logic [`IDIV_WIDTH-1:0]  dividend_i,
    input  logic [`IDIV_WIDTH-1:0]  divisor_i,
    input  logic                    signed_div_i,

    output logic                    v_o,
    input  logic                    yumi_i,
    output logic [`IDIV_WIDTH-1:0]  quotient_o,
    output logic [`IDIV_WIDTH-1:0]  remainder_o
);

    // controller to datapath
    idiv_pkg::opa_sel_t opa_sel;
    idiv_pkg::opb_sel_t opb_sel;
    idiv_pkg::opc_sel_t opc_sel;
    logic               opa_ld, opa_inv, opa_clr_l;
    logic               opb_ld, opb_inv, opb_clr_l;
    logic               opc_ld;
    logic               latch_signed;
    logic               adder_cin;

    // datapath status
    logic               zero_divisor;
    logic               signed_div_r;
    logic               adder_neg;
    logic               opa_neg;
    logic               opc_neg;

    idiv_controller u_controller (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .v_i            (v_i),
        .ready_o        (ready_o),
        .zero_divisor_i (zero_divisor),
        .signed_div_r_i (signed_div_r),
        .adder_neg_i    (adder_neg),
        .opa_neg_i      (opa_neg),
        .opc_neg_i      (opc_neg),
        .opa_sel_o      (opa_sel),
        .opa_ld_o       (opa_ld),
        .opa_inv_o      (opa_inv),
        .opa_clr_l_o    (opa_clr_l),
        .opb_sel_o      (opb_sel),
        .opb_ld_o       (opb_ld),
        .opb_inv_o      (opb_inv),
        .opb_clr_l_o    (opb_clr_l),
        .opc_sel_o      (opc_sel),
        .opc_ld_o       (opc_ld),
        .latch_signed_o (latch_signed),
        .adder_cin_o    (adder_cin),
        .v_o            (v_o),
        .yumi_i         (yumi_i)
    );

    idiv_datapath u_datapath (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dividend_i     (dividend_i),
        .divisor_i      (divisor_i),
        .signed_div_i   (signed_div_i),
        .opa_sel_i      (opa_sel),
        .opa_ld_i       (opa_ld),
        .opa_inv_i      (opa_inv),
        .opa_clr_l_i    (opa_clr_l),
        .opb_sel_i      (opb_sel),
        .opb_ld_i       (opb_ld),
        .opb_inv_i      (opb_inv),
        .opb_clr_l_i    (opb_clr_l),
        .opc_sel_i      (opc_sel),
        .opc_ld_i       (opc_ld),
        .latch_signed_i (latch_signed),
        .adder_cin_i    (adder_cin),
        .zero_divisor_o (zero_divisor),
        .signed_div_r_o (signed_div_r),
        .adder_neg_o    (adder_neg),
        .opa_neg_o      (opa_neg),
        .opc_neg_o      (opc_neg),
        .quotient_o     (quotient_o),
        .remainder_o    (remainder_o)
    );

endmodule

//--- source/idiv_datapath.sv
/*
 * Operand registers and the single adder of the divider.
 * Registers are IDIV_WIDTH+1 bits wide so signed magnitudes fit.
 * After correction the quotient sits in C and the remainder in A.
 */
`include "idiv_cfg.svh"

module idiv_datapath (
    input  logic                     clk_i,
    input  logic                     reset_i,

    input  logic [`IDIV_WIDTH-1:0]   dividend_i,
    input  logic [`IDIV_WIDTH-1:0]   divisor_i,
    input  logic                     signed_div_i,

    input  idiv_pkg::opa_sel_t       opa_sel_i,
    input  logic                     opa_ld_i,
    input  logic                     opa_inv_i,
    input  logic                     opa_clr_l_i,

    input  idiv_pkg::opb_sel_t       opb_sel_i,
    input  logic                     opb_ld_i,
    input  logic                     opb_inv_i,
    input  logic                     opb_clr_l_i,

    input  idiv_pkg::opc_sel_t       opc_sel_i,
    input  logic                     opc_ld_i,

    input  logic                     latch_signed_i,
    input  logic                     adder_cin_i,

    output logic                     zero_divisor_o,
    output logic                     signed_div_r_o,
    output logic                     adder_neg_o,
    output logic                     opa_neg_o,
    output logic                     opc_neg_o,

    output logic [`IDIV_WIDTH-1:0]   quotient_o,
    output logic [`IDIV_WIDTH-1:0]   remainder_o
);

    localparam int W = `IDIV_WIDTH;

    logic [W:0] a_r, b_r, c_r;
    logic [W:0] a_nxt, b_nxt, c_nxt;
    logic [W:0] divisor_ext;
    logic [W:0] dividend_ext;
    logic [W:0] add_in_a, add_in_b;
    logic [W:0] add_out;
    logic       signed_div_r;

    // sign extend only in signed mode
    assign divisor_ext  = {signed_div_i & divisor_i[W-1], divisor_i};
    assign dividend_ext = {signed_div_i & dividend_i[W-1], dividend_i};

    // ==============================
    // adder
    // ==============================

    // clear wins over invert
    assign add_in_a = (a_r ^ {(W+1){opa_inv_i}}) & {(W+1){opa_clr_l_i}};
    assign add_in_b = (b_r ^ {(W+1){opb_inv_i}}) & {(W+1){opb_clr_l_i}};
    assign add_out  = add_in_a + add_in_b + {{W{1'b0}}, adder_cin_i};

    // ==============================
    // operand selectors
    // ==============================

    always_comb begin
        case (opa_sel_i)
            idiv_pkg::OPA_ADDER:   a_nxt = add_out;
            idiv_pkg::OPA_DIVISOR: a_nxt = divisor_ext;
            default:               a_nxt = a_r;
        endcase
    end

    // shift left the partial remainder, next dividend bit comes from C
    always_comb begin
        case (opb_sel_i)
            idiv_pkg::OPB_ADDER: b_nxt = add_out;
            idiv_pkg::OPB_COPYC: b_nxt = c_r;
            default:             b_nxt = {add_out[W-1:0], c_r[W]};
        endcase
    end

    // quotient bit is set when the new partial remainder is not negative
    always_comb begin
        case (opc_sel_i)
            idiv_pkg::OPC_ADDER:    c_nxt = add_out;
            idiv_pkg::OPC_DIVIDEND: c_nxt = dividend_ext;
            default:                c_nxt = {c_r[W-1:0], ~add_out[W]};
        endcase
    end

    // ==============================
    // registers
    // ==============================

    always_ff @(posedge clk_i) begin
        if (opa_ld_i) begin
            a_r <= a_nxt;
        end
        if (opb_ld_i) begin
            b_r <= b_nxt;
        end
        if (opc_ld_i) begin
            c_r <= c_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            signed_div_r <= 1'b0;
        end else if (latch_signed_i) begin
            signed_div_r <= signed_div_i;
        end
    end

    // status back to the controller
    assign zero_divisor_o = (a_r == '0);
    assign signed_div_r_o = signed_div_r;
    assign adder_neg_o    = add_out[W];
    assign opa_neg_o      = a_r[W];
    assign opc_neg_o      = c_r[W];

    assign quotient_o  = c_r[W-1:0];
    assign remainder_o = a_r[W-1:0];

endmodule

//--- source/idiv_controller.sv
/*
 * Sequencer for the non-restoring divider. One division in flight at a time.
 * Latency depends on the operand signs and on the final remainder sign.
 * yumi_i is only honoured in DONE.
 */
`include "idiv_cfg.svh"

module idiv_controller (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  v_i,
    output logic                  ready_o,

    input  logic                  zero_divisor_i,
    input  logic                  signed_div_r_i,
    input  logic                  adder_neg_i,
    input  logic                  opa_neg_i,
    input  logic                  opc_neg_i,

    output idiv_pkg::opa_sel_t    opa_sel_o,
    output logic                  opa_ld_o,
    output logic                  opa_inv_o,
    output logic                  opa_clr_l_o,

    output idiv_pkg::opb_sel_t    opb_sel_o,
    output logic                  opb_ld_o,
    output logic                  opb_inv_o,
    output logic                  opb_clr_l_o,

    output idiv_pkg::opc_sel_t    opc_sel_o,
    output logic                  opc_ld_o,

    output logic                  latch_signed_o,
    output logic                  adder_cin_o,

    output logic                  v_o,
    input  logic                  yumi_i
);

    localparam int unsigned CALC_LAST = `IDIV_WIDTH;

    idiv_pkg::ctrl_state_t state_r, state_nxt;

    logic [`IDIV_CNT_WIDTH-1:0] calc_cnt;
    logic                       calc_done;
    logic                       add_neg_last;
    logic                       q_neg;
    logic                       r_neg;
    logic                       neg_ld;

    // ==============================
    // sign flags
    // ==============================

    // previous adder sign picks add or subtract for the next step
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            add_neg_last <= 1'b0;
            q_neg        <= 1'b0;
            r_neg        <= 1'b0;
        end else begin
            add_neg_last <= adder_neg_i;
            if (neg_ld) begin
                // quotient is negative when operand signs differ
                q_neg <= (opa_neg_i ^ opc_neg_i) & signed_div_r_i;
                // remainder follows the dividend sign
                r_neg <= opc_neg_i & signed_div_r_i;
            end
        end
    end

    // ==============================
    // iteration counter
    // ==============================

    assign calc_done = (calc_cnt == CALC_LAST[`IDIV_CNT_WIDTH-1:0]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            calc_cnt <= '0;
        end else if (state_r == idiv_pkg::CALC) begin
            calc_cnt <= calc_done ? '0 : calc_cnt + 1'b1;
        end
    end

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= idiv_pkg::WAIT;
        end else begin
            state_r <= state_nxt;
        end
    end

    always_comb begin
        state_nxt      = state_r;
        opa_sel_o      = idiv_pkg::OPA_HOLD;
        opa_ld_o       = 1'b0;
        opa_inv_o      = !add_neg_last;
        opa_clr_l_o    = 1'b1;
        opb_sel_o      = idiv_pkg::OPB_SHIFT;
        opb_ld_o       = 1'b0;
        opb_inv_o      = 1'b0;
        opb_clr_l_o    = 1'b1;
        opc_sel_o      = idiv_pkg::OPC_SHIFT;
        opc_ld_o       = 1'b0;
        latch_signed_o = 1'b0;
        adder_cin_o    = !add_neg_last;
        neg_ld         = 1'b0;

        case (state_r)
            idiv_pkg::WAIT: begin
                if (v_i) begin
                    opa_sel_o      = idiv_pkg::OPA_DIVISOR;
                    opa_ld_o       = 1'b1;
                    opc_sel_o      = idiv_pkg::OPC_DIVIDEND;
                    opc_ld_o       = 1'b1;
                    latch_signed_o = 1'b1;
                    state_nxt      = idiv_pkg::NEG0;
                end
            end

            // A <= -A when the divisor is negative, B keeps a copy of the dividend
            idiv_pkg::NEG0: begin
                neg_ld      = 1'b1;
                opa_sel_o   = idiv_pkg::OPA_ADDER;
                opa_inv_o   = 1'b1;
                opa_ld_o    = opa_neg_i & signed_div_r_i;
                opb_clr_l_o = 1'b0;
                opb_sel_o   = idiv_pkg::OPB_COPYC;
                opb_ld_o    = 1'b1;
                adder_cin_o = 1'b1;
                state_nxt   = (opc_neg_i & signed_div_r_i) ? idiv_pkg::NEG1 : idiv_pkg::SHIFT;
            end

            // C <= -B, the dividend magnitude
            idiv_pkg::NEG1: begin
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opc_sel_o   = idiv_pkg::OPC_ADDER;
                opc_ld_o    = 1'b1;
                state_nxt   = idiv_pkg::SHIFT;
            end

            // adder gives zero, so B starts from C's top bit
            idiv_pkg::SHIFT: begin
                opa_clr_l_o = 1'b0;
                opa_inv_o   = 1'b0;
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b0;
                opb_ld_o    = 1'b1;
                opc_ld_o    = 1'b1;
                state_nxt   = idiv_pkg::CALC;
            end

            idiv_pkg::CALC: begin
                opb_sel_o = calc_done ? idiv_pkg::OPB_ADDER : idiv_pkg::OPB_SHIFT;
                opb_ld_o  = 1'b1;
                opc_ld_o  = 1'b1;
                if (calc_done) begin
                    state_nxt = adder_neg_i ? idiv_pkg::REPAIR : idiv_pkg::REMAIN;
                end
            end

            // add the divisor back to a negative remainder
            idiv_pkg::REPAIR: begin
                opa_inv_o   = 1'b0;
                adder_cin_o = 1'b0;
                opb_sel_o   = idiv_pkg::OPB_ADDER;
                opb_ld_o    = 1'b1;
                state_nxt   = idiv_pkg::REMAIN;
            end

            // A <= +/-B as the final remainder, B takes the quotient
            idiv_pkg::REMAIN: begin
                opa_sel_o   = idiv_pkg::OPA_ADDER;
                opa_ld_o    = 1'b1;
                opa_clr_l_o = 1'b0;
                opb_inv_o   = r_neg;
                adder_cin_o = r_neg;
                opb_sel_o   = idiv_pkg::OPB_COPYC;
                opb_ld_o    = 1'b1;
                state_nxt   = (zero_divisor_i | !q_neg) ? idiv_pkg::DONE : idiv_pkg::QUOT;
            end

            idiv_pkg::QUOT: begin
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opc_sel_o   = idiv_pkg::OPC_ADDER;
                opc_ld_o    = 1'b1;
                state_nxt   = idiv_pkg::DONE;
            end

            idiv_pkg::DONE: begin
                if (yumi_i) begin
                    state_nxt = idiv_pkg::WAIT;
                end
            end

            default: begin
                state_nxt = idiv_pkg::WAIT;
            end
        endcase
    end

    assign ready_o = (state_r == idiv_pkg::WAIT);
    assign v_o     = (state_r == idiv_pkg::DONE);

endmodule

//--- source/idiv_pkg.sv
/*
 * Shared types of the iterative divider.
 * Operand selector encodings are one-hot and must match the datapath muxes.
 */
package idiv_pkg;

    // controller sequence
    typedef enum logic [3:0] {
        WAIT,
        NEG0,
        NEG1,
        SHIFT,
        CALC,
        REPAIR,
        REMAIN,
        QUOT,
        DONE
    } ctrl_state_t;

    // A register source
    typedef enum logic [1:0] {
        OPA_HOLD    = 2'b00,
        OPA_ADDER   = 2'b01,
        OPA_DIVISOR = 2'b10
    } opa_sel_t;

    // B register source, shift takes the adder result and C's top bit
    typedef enum logic [2:0] {
        OPB_SHIFT = 3'b001,
        OPB_ADDER = 3'b010,
        OPB_COPYC = 3'b100
    } opb_sel_t;

    // C register source, shift takes in the new quotient bit
    typedef enum logic [2:0] {
        OPC_SHIFT    = 3'b001,
        OPC_ADDER    = 3'b010,
        OPC_DIVIDEND = 3'b100
    } opc_sel_t;

endpackage

//--- source/idiv_cfg.svh
/*
 * Divider width settings. IDIV_WIDTH must be at least 2.
 * IDIV_CNT_WIDTH is derived and should not be overridden.
 */
`ifndef IDIV_CFG_SVH
`define IDIV_CFG_SVH

// operand and result width in bits
`define IDIV_WIDTH 32

// enough bits to count 0..IDIV_WIDTH inclusive
`define IDIV_CNT_WIDTH ($clog2(`IDIV_WIDTH + 1))

`endif
